/* Makefile */
sim:
	verilator --binary --timing --assert -j 0 --top-module tb_rv_core -f vlog.f -o sim_tb_rv_core
	./obj_dir/sim_tb_rv_core | tee sim.log
	! grep -q "Some tests failed" sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* rv_core.sv */
`default_nettype none
`timescale 1ns/10ps

module rv_core import rv_pkg::*;
(
    input  wire logic            i_clk,
    input  wire logic            i_arst_n,
    output logic                 o_instr_req,
    output logic [XLEN-1:0]      o_instr_addr,
    input  wire logic            i_instr_ack,
    input  wire logic [XLEN-1:0] i_instr_data,
    output logic                 o_data_req,
    output logic [XLEN-1:0]      o_data_addr,
    output logic [XLEN-1:0]      o_data_wdata
);

    logic                  f_valid;
    instr_u                f_instr;
    logic [XLEN-1:0]       f_pc;

    logic [REG_ADDR_W-1:0] r_rs1;
    logic [REG_ADDR_W-1:0] r_rs2;
    logic [XLEN-1:0]       r_rdata1;
    logic [XLEN-1:0]       r_rdata2;

    logic                  d_valid;
    logic [XLEN-1:0]       d_pc;
    logic [XLEN-1:0]       d_op1;
    logic [XLEN-1:0]       d_op2;
    logic [XLEN-1:0]       d_imm;
    logic [REG_ADDR_W-1:0] d_rs1;
    logic [REG_ADDR_W-1:0] d_rs2;
    logic [REG_ADDR_W-1:0] d_rd;
    logic                  d_reg_write;
    alu_op_e               d_alu_op;
    logic                  d_use_imm;
    br_cond_e              d_br_cond;
    logic                  d_is_branch;
    logic                  d_is_jal;
    logic                  d_is_jalr;
    logic                  d_is_store;

    logic                  x_redirect;
    logic [XLEN-1:0]       x_target;
    logic                  x_we;
    logic [REG_ADDR_W-1:0] x_rd;
    logic [XLEN-1:0]       x_wdata;

    rv_fetch rv_fetch_i
    (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_redirect   (x_redirect),
        .i_target     (x_target),
        .o_instr_req  (o_instr_req),
        .o_instr_addr (o_instr_addr),
        .i_instr_ack  (i_instr_ack),
        .i_instr_data (i_instr_data),
        .o_valid      (f_valid),
        .o_instr      (f_instr),
        .o_pc         (f_pc)
    );

    rv_decode rv_decode_i
    (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_flush      (x_redirect),
        .i_valid      (f_valid),
        .i_instr      (f_instr),
        .i_pc         (f_pc),
        .o_rs1        (r_rs1),
        .o_rs2        (r_rs2),
        .i_rdata1     (r_rdata1),
        .i_rdata2     (r_rdata2),
        .o_valid      (d_valid),
        .o_pc         (d_pc),
        .o_op1        (d_op1),
        .o_op2        (d_op2),
        .o_imm        (d_imm),
        .o_rs1_q      (d_rs1),
        .o_rs2_q      (d_rs2),
        .o_rd         (d_rd),
        .o_reg_write  (d_reg_write),
        .o_alu_op     (d_alu_op),
        .o_use_imm    (d_use_imm),
        .o_br_cond    (d_br_cond),
        .o_is_branch  (d_is_branch),
        .o_is_jal     (d_is_jal),
        .o_is_jalr    (d_is_jalr),
        .o_is_store   (d_is_store)
    );

    rv_regs rv_regs_i
    (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_rs1        (r_rs1),
        .i_rs2        (r_rs2),
        .o_rdata1     (r_rdata1),
        .o_rdata2     (r_rdata2),
        .i_we         (x_we),
        .i_rd         (x_rd),
        .i_wdata      (x_wdata)
    );

    rv_execute rv_execute_i
    (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_valid      (d_valid),
        .i_pc         (d_pc),
        .i_op1        (d_op1),
        .i_op2        (d_op2),
        .i_imm        (d_imm),
        .i_rs1_q      (d_rs1),
        .i_rs2_q      (d_rs2),
        .i_rd         (d_rd),
        .i_reg_write  (d_reg_write),
        .i_alu_op     (d_alu_op),
        .i_use_imm    (d_use_imm),
        .i_br_cond    (d_br_cond),
        .i_is_branch  (d_is_branch),
        .i_is_jal     (d_is_jal),
        .i_is_jalr    (d_is_jalr),
        .i_is_store   (d_is_store),
        .o_redirect   (x_redirect),
        .o_target     (x_target),
        .o_we         (x_we),
        .o_rd         (x_rd),
        .o_wdata      (x_wdata),
        .o_data_req   (o_data_req),
        .o_data_addr  (o_data_addr),
        .o_data_wdata (o_data_wdata)
    );

endmodule

`default_nettype wire

/* rv_decode.sv */
`default_nettype none
`timescale 1ns/10ps

module rv_decode import rv_pkg::*;
(
    input  wire logic                  i_clk,
    input  wire logic                  i_arst_n,
    input  wire logic                  i_flush,
    input  wire logic                  i_valid,
    input  wire instr_u                i_instr,
    input  wire logic [XLEN-1:0]       i_pc,
    output logic [REG_ADDR_W-1:0]      o_rs1,
    output logic [REG_ADDR_W-1:0]      o_rs2,
    input  wire logic [XLEN-1:0]       i_rdata1,
    input  wire logic [XLEN-1:0]       i_rdata2,
    output logic                       o_valid,
    output logic [XLEN-1:0]            o_pc,
    output logic [XLEN-1:0]            o_op1,
    output logic [XLEN-1:0]            o_op2,
    output logic [XLEN-1:0]            o_imm,
    output logic [REG_ADDR_W-1:0]      o_rs1_q,
    output logic [REG_ADDR_W-1:0]      o_rs2_q,
    output logic [REG_ADDR_W-1:0]      o_rd,
    output logic                       o_reg_write,
    output alu_op_e                    o_alu_op,
    output logic                       o_use_imm,
    output br_cond_e                   o_br_cond,
    output logic                       o_is_branch,
    output logic                       o_is_jal,
    output logic                       o_is_jalr,
    output logic                       o_is_store
);

    logic [31:0]     w;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm;
    logic            reg_write;
    logic            use_imm;
    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic            is_store;
    alu_op_e         alu_op;
    alu_op_e         alu_f3;

    assign w = i_instr;

    assign imm_i = {{20{w[31]}}, w[31:20]};
    assign imm_s = {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo};
    assign imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    assign imm_u = {w[31:12], 12'b0};
    assign imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};

    assign o_rs1 = i_instr.r.rs1;
    assign o_rs2 = i_instr.r.rs2;

    // Common to OP and OP-IMM
    always_comb
    begin
        case (i_instr.r.funct3)
            F3_ADD:  alu_f3 = ALU_ADD;
            F3_SLL:  alu_f3 = ALU_SLL;
            F3_SLT:  alu_f3 = ALU_SLT;
            F3_SLTU: alu_f3 = ALU_SLTU;
            F3_XOR:  alu_f3 = ALU_XOR;
            F3_SRL:  alu_f3 = (i_instr.r.funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            F3_OR:   alu_f3 = ALU_OR;
            default: alu_f3 = ALU_AND;
        endcase
    end

    always_comb
    begin
        imm       = imm_i;
        alu_op    = ALU_ADD;
        reg_write = 1'b0;
        use_imm   = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        is_store  = 1'b0;
        case (i_instr.r.opcode)
            OPC_OP:
            begin
                reg_write = 1'b1;
                if (i_instr.r.funct3 == F3_ADD && i_instr.r.funct7 == F7_ALT)
                    alu_op = ALU_SUB;
                else
                    alu_op = alu_f3;
            end
            OPC_OP_IMM:
            begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                alu_op    = alu_f3;
            end
            OPC_LUI:
            begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                imm       = imm_u;
                alu_op    = ALU_PASS_B;
            end
            OPC_BRANCH:
            begin
                is_branch = 1'b1;
                imm       = imm_b;
            end
            OPC_JAL:
            begin
                reg_write = 1'b1;
                is_jal    = 1'b1;
                imm       = imm_j;
            end
            OPC_JALR:
            begin
                reg_write = 1'b1;
                is_jalr   = 1'b1;
            end
            OPC_STORE:
            begin
                is_store = (i_instr.s.funct3 == F3_SW);  // Word stores only
                imm      = imm_s;
            end
            default: ;                                  // Executes as a no-op
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_valid <= 1'b0;
        else
            o_valid <= i_valid & ~i_flush;
    end

    always_ff @(posedge i_clk)
    begin
        o_pc        <= i_pc;
        o_op1       <= i_rdata1;
        o_op2       <= i_rdata2;
        o_imm       <= imm;
        o_rs1_q     <= i_instr.r.rs1;
        o_rs2_q     <= i_instr.r.rs2;
        o_rd        <= i_instr.r.rd;
        o_reg_write <= reg_write;
        o_alu_op    <= alu_op;
        o_use_imm   <= use_imm;
        o_br_cond   <= br_cond_e'(i_instr.r.funct3);
        o_is_branch <= is_branch;
        o_is_jal    <= is_jal;
        o_is_jalr   <= is_jalr;
        o_is_store  <= is_store;
    end

endmodule

`default_nettype wire

/* rv_execute.sv */
`default_nettype none
`timescale 1ns/10ps

module rv_execute import rv_pkg::*;
(
    input  wire logic                  i_clk,
    input  wire logic                  i_arst_n,
    input  wire logic                  i_valid,
    input  wire logic [XLEN-1:0]       i_pc,
    input  wire logic [XLEN-1:0]       i_op1,
    input  wire logic [XLEN-1:0]       i_op2,
    input  wire logic [XLEN-1:0]       i_imm,
    input  wire logic [REG_ADDR_W-1:0] i_rs1_q,
    input  wire logic [REG_ADDR_W-1:0] i_rs2_q,
    input  wire logic [REG_ADDR_W-1:0] i_rd,
    input  wire logic                  i_reg_write,
    input  wire alu_op_e               i_alu_op,
    input  wire logic                  i_use_imm,
    input  wire br_cond_e              i_br_cond,
    input  wire logic                  i_is_branch,
    input  wire logic                  i_is_jal,
    input  wire logic                  i_is_jalr,
    input  wire logic                  i_is_store,
    output logic                       o_redirect,
    output logic [XLEN-1:0]            o_target,
    output logic                       o_we,
    output logic [REG_ADDR_W-1:0]      o_rd,
    output logic [XLEN-1:0]            o_wdata,
    output logic                       o_data_req,
    output logic [XLEN-1:0]            o_data_addr,
    output logic [XLEN-1:0]            o_data_wdata
);

    logic                  prev_we;
    logic [REG_ADDR_W-1:0] prev_rd;
    logic [XLEN-1:0]       prev_data;
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;
    logic [XLEN-1:0]       alu_b;
    logic [XLEN-1:0]       alu_res;
    logic [XLEN-1:0]       base_sum;
    logic                  take;

    // Forward last result
    assign op1 = (prev_we && prev_rd != '0 && prev_rd == i_rs1_q) ? prev_data : i_op1;
    assign op2 = (prev_we && prev_rd != '0 && prev_rd == i_rs2_q) ? prev_data : i_op2;

    assign alu_b    = i_use_imm ? i_imm : op2;
    assign base_sum = op1 + i_imm;                  // jalr target and store address

    always_comb
    begin
        case (i_alu_op)
            ALU_ADD:  alu_res = op1 + alu_b;
            ALU_SUB:  alu_res = op1 - alu_b;
            ALU_AND:  alu_res = op1 & alu_b;
            ALU_OR:   alu_res = op1 | alu_b;
            ALU_XOR:  alu_res = op1 ^ alu_b;
            ALU_SLL:  alu_res = op1 << alu_b[4:0];
            ALU_SRL:  alu_res = op1 >> alu_b[4:0];
            ALU_SRA:  alu_res = $signed(op1) >>> alu_b[4:0];
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(alu_b)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op1 < alu_b};
            default:  alu_res = alu_b;              // lui
        endcase
    end

    always_comb
    begin
        case (i_br_cond)
            BR_EQ:   take = (op1 == op2);
            BR_NE:   take = (op1 != op2);
            BR_LT:   take = ($signed(op1) < $signed(op2));
            BR_GE:   take = ($signed(op1) >= $signed(op2));
            BR_LTU:  take = (op1 < op2);
            BR_GEU:  take = (op1 >= op2);
            default: take = 1'b0;
        endcase
    end

    assign o_redirect = i_valid & (i_is_jal | i_is_jalr | (i_is_branch & take));
    assign o_target   = i_is_jalr ? {base_sum[XLEN-1:1], 1'b0} : i_pc + i_imm;

    assign o_we    = i_valid & i_reg_write;
    assign o_rd    = i_rd;
    assign o_wdata = (i_is_jal | i_is_jalr) ? i_pc + 32'd4 : alu_res;

    assign o_data_req   = i_valid & i_is_store;
    assign o_data_addr  = base_sum;
    assign o_data_wdata = op2;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            prev_we <= 1'b0;
        else
            prev_we <= o_we;
    end

    always_ff @(posedge i_clk)
    begin
        prev_rd   <= o_rd;
        prev_data <= o_wdata;
    end

    store_align_a: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_data_req |-> o_data_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* rv_fetch.sv */
`default_nettype none
`timescale 1ns/10ps

module rv_fetch import rv_pkg::*;
(
    input  wire logic            i_clk,
    input  wire logic            i_arst_n,
    input  wire logic            i_redirect,
    input  wire logic [XLEN-1:0] i_target,
    output logic                 o_instr_req,
    output logic [XLEN-1:0]      o_instr_addr,
    input  wire logic            i_instr_ack,
    input  wire logic [XLEN-1:0] i_instr_data,
    output logic                 o_valid,
    output instr_u               o_instr,
    output logic [XLEN-1:0]      o_pc
);

    logic            req_q;
    logic [XLEN-1:0] addr_q;
    logic [XLEN-1:0] tgt_q;
    logic            discard_q;
    logic            valid_q;
    instr_u          instr_q;
    logic [XLEN-1:0] pc_q;
    logic            accept;
    logic            take;

    assign accept = req_q & i_instr_ack;
    assign take   = accept & ~discard_q & ~i_redirect;  // Word is on the right path

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            req_q     <= 1'b0;
            addr_q    <= RESET_ADDR;
            discard_q <= 1'b0;
            valid_q   <= 1'b0;
        end
        else
        begin
            req_q   <= 1'b1;
            valid_q <= take;
            if (accept)
            begin
                discard_q <= 1'b0;
                if (i_redirect)
                    addr_q <= i_target;
                else if (discard_q)
                    addr_q <= tgt_q;        // Pending redirect
                else
                    addr_q <= addr_q + 32'd4;
            end
            else if (i_redirect)
            begin
                discard_q <= 1'b1;          // Address must hold until ack
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_redirect)
            tgt_q <= i_target;
        instr_q <= take ? i_instr_data : NOP_INSTR;
        pc_q    <= addr_q;
    end

    assign o_instr_req  = req_q;
    assign o_instr_addr = addr_q;
    assign o_valid      = valid_q;
    assign o_instr      = instr_q;
    assign o_pc         = pc_q;

    addr_stable_a: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_instr_req && !i_instr_ack |=> $stable(o_instr_addr));

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_ADDR = 32'h0000_0000;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // ALU funct3 codes, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_SW   = 3'b010;

    localparam logic [6:0] F7_ALT = 7'b0100000;   // sub and sra

    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;  // addi x0,x0,0

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    // Encoded as the branch funct3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    typedef union packed {
        r_type_t r;
        s_type_t s;
    } instr_u;

endpackage

`default_nettype wire

/* rv_regs.sv */
`default_nettype none
`timescale 1ns/10ps

module rv_regs import rv_pkg::*;
(
    input  wire logic                  i_clk,
    input  wire logic                  i_arst_n,
    input  wire logic [REG_ADDR_W-1:0] i_rs1,
    input  wire logic [REG_ADDR_W-1:0] i_rs2,
    output logic [XLEN-1:0]            o_rdata1,
    output logic [XLEN-1:0]            o_rdata2,
    input  wire logic                  i_we,
    input  wire logic [REG_ADDR_W-1:0] i_rd,
    input  wire logic [XLEN-1:0]       i_wdata
);

    logic [XLEN-1:0] regs [1:31];

    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        else if (i_we && i_rd == addr)
            return i_wdata;                 // Same-cycle write pass-through
        else
            return regs[addr];
    endfunction

    always_comb
    begin
        o_rdata1 = read_port(i_rs1);
        o_rdata2 = read_port(i_rs2);
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_we && i_rd != '0)
        begin
            regs[i_rd] <= i_wdata;
        end
    end

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_rv_core import rv_pkg::*;
();

    localparam int          TIMEOUT   = 2000;
    localparam int          SLOT_BASE = 32'h100;
    localparam logic [31:0] SENTINEL  = 32'h0000_07FC;   // Last store of every program

    logic            i_clk        = 1'b0;
    logic            i_arst_n     = 1'b0;
    logic            i_instr_ack  = 1'b0;
    logic [XLEN-1:0] i_instr_data = '0;
    logic            o_instr_req;
    logic [XLEN-1:0] o_instr_addr;
    logic            o_data_req;
    logic [XLEN-1:0] o_data_addr;
    logic [XLEN-1:0] o_data_wdata;

    logic [31:0] imem [0:255];
    logic [1:0]  ack_delay = 2'd0;
    int          seed      = 28;
    int          prog_len  = 0;
    int          errors    = 0;
    int          checks    = 0;
    int          tests     = 0;
    int          failed    = 0;
    logic [31:0] got_addr [$];
    logic [31:0] got_data [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    rv_core rv_core_i
    (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .o_instr_req  (o_instr_req),
        .o_instr_addr (o_instr_addr),
        .i_instr_ack  (i_instr_ack),
        .i_instr_data (i_instr_data),
        .o_data_req   (o_data_req),
        .o_data_addr  (o_data_addr),
        .o_data_wdata (o_data_wdata)
    );

    initial
    begin
        forever #4 i_clk = ~i_clk;
    end

    // Instruction memory with 0 to 3 cycles of wait before each ack
    always @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            i_instr_ack <= 1'b0;
            ack_delay   <= 2'd0;
        end
        else if (i_instr_ack)
        begin
            i_instr_ack <= 1'b0;                    // Word taken on this edge
            ack_delay   <= 2'($random(seed));
        end
        else if (o_instr_req)
        begin
            if (ack_delay == 2'd0)
            begin
                i_instr_ack  <= 1'b1;
                i_instr_data <= imem[o_instr_addr[9:2]];
            end
            else
            begin
                ack_delay <= ack_delay - 2'd1;
            end
        end
    end

    always @(negedge i_clk)
    begin
        if (o_data_req)
        begin
            got_addr.push_back(o_data_addr);
            got_data.push_back(o_data_wdata);
        end
    end

    function automatic logic [31:0] r_word(input logic [6:0] f7, input int rs2, input int rs1,
                                           input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] i_word(input int imm, input int rs1, input logic [2:0] f3,
                                           input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_word(input int imm, input int rs2, input int rs1,
                                           input logic [2:0] f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_word(input int imm, input int rs2, input int rs1,
                                           input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_word(input int imm20, input int rd);
        return {imm20[19:0], rd[4:0], OPC_LUI};
    endfunction

    function automatic logic [31:0] j_word(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %s: got %08h, expected %08h", what, got, exp);
        end
    endtask

    task automatic put(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic store_expect(input int rs2, input int slot, input logic [31:0] value);
        put(s_word(SLOT_BASE + 4 * slot, rs2, 0, F3_SW));
        exp_addr.push_back(32'(SLOT_BASE + 4 * slot));
        exp_data.push_back(value);
    endtask

    // A store that must never reach the data port
    task automatic store_marker(input int slot);
        put(s_word(SLOT_BASE + 4 * slot, 0, 0, F3_SW));
    endtask

    task automatic start_test();
        @(posedge i_clk);
        i_arst_n <= 1'b0;
        for (int i = 0; i < 256; i++)
            imem[i] = {i[11:0], 20'h00013};         // addi x0,x0,i
        prog_len = 0;
        got_addr.delete();
        got_data.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic run_program(input string name);
        int cycles;
        int errs_at_start;
        bit seen;
        errs_at_start = errors;
        put(s_word(SENTINEL, 0, 0, F3_SW));
        put(j_word(0, 0));                          // Self-jump
        repeat (5) @(posedge i_clk);
        i_arst_n <= 1'b1;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TIMEOUT)
        begin
            @(posedge i_clk);
            cycles++;
            if (got_addr.size() > 0)
                seen = (got_addr[$] == SENTINEL);
        end
        if (!seen)
        begin
            errors++;
            $display("Timeout: %s did not reach its final store within %0d cycles", name, TIMEOUT);
        end
        else
        begin
            check("o_data_req count", 32'(got_addr.size()), 32'(exp_addr.size() + 1));
            for (int k = 0; k < exp_addr.size() && k < got_addr.size(); k++)
            begin
                check($sformatf("o_data_addr[%0d]", k), got_addr[k], exp_addr[k]);
                check($sformatf("o_data_wdata[%0d]", k), got_data[k], exp_data[k]);
            end
        end
        tests++;
        if (errors != errs_at_start)
            failed++;
        $display("Test %s finished with %0d errors", name, errors - errs_at_start);
    endtask

    task automatic test_imm_alu();
        logic [31:0] a;
        logic [31:0] u;
        start_test();
        a = 32'hFFFF_FFFB;                          // -5
        u = 32'h1234_5000 + 32'h678;
        put(i_word(-5, 0, F3_ADD, 1, OPC_OP_IMM));
        put(u_word(32'h12345, 2));
        put(i_word(32'h678, 2, F3_ADD, 2, OPC_OP_IMM));
        put(i_word(32'h0F0, 2, F3_AND, 3, OPC_OP_IMM));
        put(i_word(-256, 2, F3_OR, 4, OPC_OP_IMM));
        put(i_word(32'h555, 1, F3_XOR, 5, OPC_OP_IMM));
        put(i_word(1, 1, F3_SLT, 6, OPC_OP_IMM));
        put(i_word(1, 1, F3_SLTU, 7, OPC_OP_IMM));
        put(i_word(4, 2, F3_SLL, 8, OPC_OP_IMM));
        put(i_word(4, 1, F3_SRL, 9, OPC_OP_IMM));
        put(i_word(32'h401, 1, F3_SRL, 10, OPC_OP_IMM));     // srai by 1
        store_expect(1, 0, a);
        store_expect(2, 1, u);
        store_expect(3, 2, u & 32'h0F0);
        store_expect(4, 3, u | 32'hFFFF_FF00);
        store_expect(5, 4, a ^ 32'h555);
        store_expect(6, 5, ($signed(a) < 32'sd1) ? 32'd1 : 32'd0);
        store_expect(7, 6, (a < 32'd1) ? 32'd1 : 32'd0);
        store_expect(8, 7, u << 4);
        store_expect(9, 8, a >> 4);
        store_expect(10, 9, $signed(a) >>> 1);
        run_program("imm_alu");
    endtask

    task automatic test_reg_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        start_test();
        a = 32'hFFFF_FFEC;                          // -20
        b = 32'd3;
        c = 32'd7;
        put(i_word(-20, 0, F3_ADD, 1, OPC_OP_IMM));
        put(i_word(3, 0, F3_ADD, 2, OPC_OP_IMM));
        put(i_word(7, 0, F3_ADD, 3, OPC_OP_IMM));
        put(r_word(7'h00, 2, 1, F3_ADD, 4));
        put(r_word(7'h20, 1, 2, F3_ADD, 5));        // sub x5,x2,x1
        put(r_word(7'h00, 3, 1, F3_AND, 6));
        put(r_word(7'h00, 3, 1, F3_OR, 7));
        put(r_word(7'h00, 2, 1, F3_XOR, 8));
        put(r_word(7'h00, 3, 2, F3_SLL, 9));
        put(r_word(7'h00, 2, 1, F3_SRL, 10));
        put(r_word(7'h20, 2, 1, F3_SRL, 11));       // sra
        put(r_word(7'h00, 2, 1, F3_SLT, 12));
        put(r_word(7'h00, 2, 1, F3_SLTU, 13));
        put(r_word(7'h00, 1, 2, F3_SLTU, 14));
        store_expect(4, 0, a + b);
        store_expect(5, 1, b - a);
        store_expect(6, 2, a & c);
        store_expect(7, 3, a | c);
        store_expect(8, 4, a ^ b);
        store_expect(9, 5, b << c[4:0]);
        store_expect(10, 6, a >> b[4:0]);
        store_expect(11, 7, $signed(a) >>> b[4:0]);
        store_expect(12, 8, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        store_expect(13, 9, (a < b) ? 32'd1 : 32'd0);
        store_expect(14, 10, (b < a) ? 32'd1 : 32'd0);
        run_program("reg_alu");
    endtask

    task automatic test_bypass();
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] v3;
        logic [31:0] v4;
        logic [31:0] v5;
        logic [31:0] v6;
        start_test();
        v1 = 32'd1 + 32'd1;
        v2 = v1 + v1;
        v3 = v2 - v1;
        v4 = v3 ^ v2;
        v5 = (v4 << 3) - 32'd1;
        v6 = v5 + v5;
        put(i_word(1, 0, F3_ADD, 1, OPC_OP_IMM));
        put(r_word(7'h00, 1, 1, F3_ADD, 1));
        put(r_word(7'h00, 1, 1, F3_ADD, 2));
        put(r_word(7'h20, 1, 2, F3_ADD, 3));
        put(r_word(7'h00, 2, 3, F3_XOR, 4));
        put(i_word(3, 4, F3_SLL, 5, OPC_OP_IMM));
        put(i_word(-1, 5, F3_ADD, 5, OPC_OP_IMM));  // Own source rewritten
        put(r_word(7'h00, 5, 5, F3_ADD, 6));
        store_expect(6, 0, v6);
        store_expect(5, 1, v5);
        store_expect(4, 2, v4);
        store_expect(3, 3, v3);
        store_expect(2, 4, v2);
        store_expect(1, 5, v1);
        // Store base taken from the instruction just before
        put(i_word(32'h18, 0, F3_ADD, 7, OPC_OP_IMM));
        put(s_word(SLOT_BASE, 6, 7, F3_SW));
        exp_addr.push_back(32'(SLOT_BASE + 32'h18));
        exp_data.push_back(v6);
        run_program("bypass");
    endtask

    task automatic branch_case(input logic [2:0] f3, input int rs1, input int rs2,
                               input bit taken, input int k);
        put(b_word(8, rs2, rs1, f3));               // Skips the marker when taken
        if (taken)
        begin
            store_marker(2 * k);
        end
        else
        begin
            store_expect(0, 2 * k, 32'd0);
        end
        store_expect(4, 2 * k + 1, 32'h77);
    endtask

    task automatic test_branches();
        start_test();
        put(i_word(-1, 0, F3_ADD, 1, OPC_OP_IMM));
        put(i_word(1, 0, F3_ADD, 2, OPC_OP_IMM));
        put(i_word(32'h77, 0, F3_ADD, 4, OPC_OP_IMM));
        branch_case(3'b000, 1, 1, 1'b1, 0);         // beq
        branch_case(3'b000, 1, 2, 1'b0, 1);
        branch_case(3'b001, 1, 2, 1'b1, 2);         // bne
        branch_case(3'b001, 1, 1, 1'b0, 3);
        branch_case(3'b100, 1, 2, 1'b1, 4);         // blt, -1 < 1
        branch_case(3'b100, 2, 1, 1'b0, 5);
        branch_case(3'b101, 2, 1, 1'b1, 6);         // bge
        branch_case(3'b101, 1, 2, 1'b0, 7);
        branch_case(3'b110, 2, 1, 1'b1, 8);         // bltu, 1 < ffffffff
        branch_case(3'b110, 1, 2, 1'b0, 9);
        branch_case(3'b111, 1, 2, 1'b1, 10);        // bgeu
        branch_case(3'b111, 2, 1, 1'b0, 11);
        run_program("branches");
    endtask

    task automatic test_jumps();
        start_test();
        put(j_word(12, 1));                         // pc 0, to 12
        store_marker(0);
        store_marker(1);
        store_expect(1, 2, 32'd0 + 32'd4);
        put(i_word(33, 0, F3_ADD, 6, OPC_OP_IMM));
        put(i_word(4, 6, 3'b000, 7, OPC_JALR));     // pc 20, 37 with bit 0 cleared
        store_marker(3);
        store_marker(4);
        store_marker(5);
        store_expect(7, 6, 32'd20 + 32'd4);
        put(j_word(12, 8));                         // pc 40, to 52
        store_marker(7);
        put(j_word(12, 0));                         // pc 48, to 60
        store_expect(8, 8, 32'd40 + 32'd4);
        put(j_word(-8, 9));                         // pc 56, back to 48
        store_expect(9, 9, 32'd56 + 32'd4);
        run_program("jumps");
    endtask

    task automatic test_nop_x0();
        start_test();
        put(i_word(32'h55, 0, F3_ADD, 1, OPC_OP_IMM));
        put(i_word(0, 0, 3'b010, 1, 7'b0000011));   // lw x1 is not decoded
        put(i_word(32'h123, 1, F3_ADD, 1, 7'b1111111));
        put(i_word(7, 1, F3_ADD, 0, OPC_OP_IMM));   // addi x0,x1,7
        put(r_word(7'h00, 0, 0, F3_ADD, 2));
        put(s_word(SLOT_BASE + 4 * 3, 1, 0, 3'b001));  // sh
        store_expect(1, 0, 32'h55);
        put(u_word(32'hABCDE, 0));
        store_expect(0, 1, 32'd0);
        store_expect(2, 2, 32'd0);
        run_program("nop_x0");
    endtask

    initial
    begin
        test_imm_alu();
        test_reg_alu();
        test_bypass();
        test_branches();
        test_jumps();
        test_nop_x0();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed, checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regs.sv
rv_execute.sv
rv_core.sv
tb_rv_core.sv
